/* source/fifo_geometry_pkg.sv */
package fifo_geometry_pkg;

  // ----------------------------------------
  // FIFO geometry
  // ----------------------------------------

  // Number of entries held by the FIFO
  // Six is deliberately not a power of two
  localparam int depth = 6;

  // Width of a read or write pointer, addressing entries 0 to depth-1
  localparam int ptr_width = $clog2(depth);

  // Width of the occupancy count, which must reach depth itself
  localparam int count_width = $clog2(depth + 1);

  // Largest value a pointer may take before it wraps back to zero
  localparam int ptr_max = depth - 1;

endpackage

/* source/fifo_payload_pkg.sv */
package fifo_payload_pkg;

  // ----------------------------------------
  // Payload carried through the FIFO
  // ----------------------------------------

  // Width of one stored word in bits
  localparam int data_width = 16;

  // One payload word as it is pushed, stored and popped
  typedef logic [data_width-1:0] data_t;

endpackage

/* source/up_down_counter.sv */
`timescale 1ns/100ps

// Up/down counter that moves by one per cycle in either direction
// The value updates one edge after incr_valid, decr_valid or reinit
// and holds while none of them is high
module up_down_counter #(
  // Largest value the counter may hold, inclusive
  parameter int max_value = 1,
  // When set the counter wraps between zero and max_value
  // When clear the plain sum is kept and the user keeps it in range
  parameter bit enable_wrap = 1,
  // Width needed to hold every value from zero to max_value
  localparam int value_width = $clog2(max_value + 1)
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   reinit,
  input  logic                   incr_valid,
  input  logic                   decr_valid,
  output logic [value_width-1:0] value
);

  // One extra bit lets an out of range step be seen before correction
  localparam int temp_width = value_width + 1;

  // Size of the counting range, which is also the wrap distance
  localparam int max_value_p1 = max_value + 1;

  // A range that is a power of two wraps for free by truncation
  localparam bit is_pow2 = (max_value_p1 & (max_value_p1 - 1)) == 0;

  // Limits resized to the widened arithmetic
  localparam logic [temp_width-1:0] max_temp = temp_width'(max_value);
  localparam logic [temp_width-1:0] span = temp_width'(max_value_p1);

  // Raw sum of the current value and the requested step
  logic [temp_width-1:0]  value_temp;
  // Step result after any wrap correction, back at value width
  logic [value_width-1:0] value_step;
  // What the register loads at the next edge when enabled
  logic [value_width-1:0] value_next;
  // High in any cycle that may change the value
  logic                   value_loaden;

  // ----------------------------------------
  // Raw step
  // ----------------------------------------

  // Simultaneous increment and decrement cancel out in the sum
  // A decrement from zero shows up as all ones in the wide result
  assign value_temp = {1'b0, value} + temp_width'(incr_valid) - temp_width'(decr_valid);

  // ----------------------------------------
  // Wrap correction
  // ----------------------------------------

  // Only a wrapping counter whose range is not a power of two needs
  // explicit correction, every other case keeps the truncated sum
  if (enable_wrap && !is_pow2) begin : gen_wrap_fix
    // The step points downward overall
    logic                  is_net_decr;
    // The raw sum left the range 0 to max_value
    logic                  out_of_bounds;
    // Raw sum moved back into range by one span
    logic [temp_width-1:0] value_wrapped;

    assign is_net_decr = decr_valid && !incr_valid;

    // An underflow also reads as large, since it wraps to all ones
    assign out_of_bounds = value_temp > max_temp;

    // Below zero lands on max_value, above max_value lands on zero
    always_comb begin
      if (!out_of_bounds) begin
        value_wrapped = value_temp;
      end else if (is_net_decr) begin
        value_wrapped = value_temp + span;
      end else begin
        value_wrapped = value_temp - span;
      end
    end

    assign value_step = value_wrapped[value_width-1:0];
  end else begin : gen_plain
    // Truncation either wraps naturally or the sum never leaves range
    assign value_step = value_temp[value_width-1:0];
  end

  // ----------------------------------------
  // State register
  // ----------------------------------------

  // Reinit wins over any change requested in the same cycle
  assign value_next = reinit ? '0 : value_step;

  // Nothing to do when no request is present
  assign value_loaden = reinit || incr_valid || decr_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      value <= '0;
    end else if (value_loaden) begin
      value <= value_next;
    end
  end

endmodule

/* source/fifo_control.sv */
`timescale 1ns/100ps

// Bookkeeping for the FIFO
// Decides which requests are accepted this cycle and keeps the write
// pointer, read pointer and occupancy in three counters
module fifo_control (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      flush,
  input  logic                                      push,
  input  logic                                      pop,
  output logic                                      write_en,
  output logic [fifo_geometry_pkg::ptr_width-1:0]   write_ptr,
  output logic [fifo_geometry_pkg::ptr_width-1:0]   read_ptr,
  output logic                                      full,
  output logic                                      empty,
  output logic [fifo_geometry_pkg::count_width-1:0] count
);

  // Requests that pass the acceptance rules in this cycle
  logic push_accept;
  logic pop_accept;

  // ----------------------------------------
  // Acceptance
  // ----------------------------------------

  // A push needs room, and a flush in the same cycle drops it
  // Room is judged on the current count only, so a push while full is
  // lost even if a pop frees an entry at the same edge
  assign push_accept = push && !full && !flush;

  // A pop needs something stored, and flush drops it the same way
  assign pop_accept = pop && !empty && !flush;

  // The storage writes at the write pointer on the same edge
  assign write_en = push_accept;

  // ----------------------------------------
  // Pointers
  // ----------------------------------------

  // Both pointers run 0 to depth-1 and wrap, depth is not a power of two
  up_down_counter #(
    .max_value  (fifo_geometry_pkg::ptr_max),
    .enable_wrap(1'b1)
  ) u_write_ptr (
    .clk       (clk),
    .rst_n     (rst_n),
    .reinit    (flush),
    .incr_valid(push_accept),
    .decr_valid(1'b0),
    .value     (write_ptr)
  );

  up_down_counter #(
    .max_value  (fifo_geometry_pkg::ptr_max),
    .enable_wrap(1'b1)
  ) u_read_ptr (
    .clk       (clk),
    .rst_n     (rst_n),
    .reinit    (flush),
    .incr_valid(pop_accept),
    .decr_valid(1'b0),
    .value     (read_ptr)
  );

  // ----------------------------------------
  // Occupancy
  // ----------------------------------------

  // Counts 0 to depth and never wraps, acceptance keeps it in range
  // A push and a pop in one cycle leave it unchanged
  up_down_counter #(
    .max_value  (fifo_geometry_pkg::depth),
    .enable_wrap(1'b0)
  ) u_occupancy (
    .clk       (clk),
    .rst_n     (rst_n),
    .reinit    (flush),
    .incr_valid(push_accept),
    .decr_valid(pop_accept),
    .value     (count)
  );

  // Status levels come straight from the registered count
  assign full  = count == fifo_geometry_pkg::count_width'(fifo_geometry_pkg::depth);
  assign empty = count == '0;

endmodule

/* source/fifo_storage.sv */
`timescale 1ns/100ps

// Entry array for the FIFO
// One write port that updates at the clock edge and one read port that
// shows the addressed entry without delay
module fifo_storage (
  input  logic                                    clk,
  input  logic                                    write_en,
  input  logic [fifo_geometry_pkg::ptr_width-1:0] write_ptr,
  input  fifo_payload_pkg::data_t                 write_data,
  input  logic [fifo_geometry_pkg::ptr_width-1:0] read_ptr,
  output fifo_payload_pkg::data_t                 read_data
);

  // One word per FIFO entry
  fifo_payload_pkg::data_t mem [fifo_geometry_pkg::depth];

  // ----------------------------------------
  // Write port
  // ----------------------------------------

  // The control block only raises write_en when there is room, so the
  // pointer always names a free entry here
  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[write_ptr] <= write_data;
    end
  end

  // ----------------------------------------
  // Read port
  // ----------------------------------------

  // The read pointer always names the oldest entry
  // Its value only means something while the FIFO holds data
  assign read_data = mem[read_ptr];

endmodule

/* source/sync_fifo.sv */
`timescale 1ns/100ps

// Synchronous FIFO of fixed depth
// Push and pop are request strobes sampled at each rising edge, and the
// FIFO answers with full and empty levels instead of a handshake
// pop_data shows the oldest entry while empty is low
module sync_fifo (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      flush,
  input  logic                                      push,
  input  fifo_payload_pkg::data_t                   push_data,
  input  logic                                      pop,
  output fifo_payload_pkg::data_t                   pop_data,
  output logic                                      full,
  output logic                                      empty,
  output logic [fifo_geometry_pkg::count_width-1:0] count
);

  // Write strobe for an accepted push
  logic                                    write_en;
  // Entry that the next accepted push fills
  logic [fifo_geometry_pkg::ptr_width-1:0] write_ptr;
  // Entry holding the oldest word
  logic [fifo_geometry_pkg::ptr_width-1:0] read_ptr;

  // ----------------------------------------
  // Control
  // ----------------------------------------

  // Acceptance, pointers and occupancy all live here
  fifo_control u_control (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush    (flush),
    .push     (push),
    .pop      (pop),
    .write_en (write_en),
    .write_ptr(write_ptr),
    .read_ptr (read_ptr),
    .full     (full),
    .empty    (empty),
    .count    (count)
  );

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  // push_data goes in at the edge that accepts the push
  fifo_storage u_storage (
    .clk       (clk),
    .write_en  (write_en),
    .write_ptr (write_ptr),
    .write_data(push_data),
    .read_ptr  (read_ptr),
    .read_data (pop_data)
  );

endmodule

/* verification/fifo_checker.sv */
`timescale 1ns/100ps

// Monitor for the FIFO
// Keeps a reference queue that follows the acceptance rules and compares
// the DUT outputs against it once per cycle at the falling edge
module fifo_checker (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      flush,
  input  logic                                      push,
  input  fifo_payload_pkg::data_t                   push_data,
  input  logic                                      pop,
  input  fifo_payload_pkg::data_t                   pop_data,
  input  logic                                      full,
  input  logic                                      empty,
  input  logic [fifo_geometry_pkg::count_width-1:0] count,
  input  logic                                      test_end,
  input  logic [8*20-1:0]                           test_name,
  output int                                        error_count,
  output int                                        tests_run,
  output int                                        tests_failed
);

  // Words the FIFO should hold, oldest at the front
  fifo_payload_pkg::data_t model_q [$];
  // Mismatches seen since the current test started
  int row_errors;

  initial begin
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    row_errors   = 0;
  end

  task automatic compare_value(input string signal_name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected 0x%0h actual 0x%0h at %0t in %0s",
               signal_name, expected, actual, $time, test_name);
      error_count++;
      row_errors++;
    end
  endtask

  // ----------------------------------------
  // Compare, then predict the next state
  // ----------------------------------------

  // Inputs change just after the rising edge, so everything is settled here
  always @(negedge clk) begin : watch
    logic exp_full;
    logic exp_empty;
    logic push_ok;
    logic pop_ok;

    if (!rst_n) begin
      // Reset clears the FIFO at the coming edge
      model_q.delete();
      row_errors = 0;
    end else begin
      exp_full  = model_q.size() == fifo_geometry_pkg::depth;
      exp_empty = model_q.size() == 0;

      compare_value("count", 32'(model_q.size()), 32'(count));
      compare_value("full", 32'(exp_full), 32'(full));
      compare_value("empty", 32'(exp_empty), 32'(empty));
      // The oldest word is only visible while something is stored
      if (!exp_empty) begin
        compare_value("pop_data", 32'(model_q[0]), 32'(pop_data));
      end

      // A push is judged on the count before any pop of the same cycle
      push_ok = push && !exp_full && !flush;
      pop_ok  = pop && !exp_empty && !flush;

      if (flush) begin
        model_q.delete();
      end else begin
        if (pop_ok) begin
          void'(model_q.pop_front());
        end
        if (push_ok) begin
          model_q.push_back(push_data);
        end
      end

      if (test_end) begin
        tests_run++;
        if (row_errors == 0) begin
          $display("Test %0s passed", test_name);
        end else begin
          $display("Test %0s failed with %0d mismatches", test_name, row_errors);
          tests_failed++;
        end
        row_errors = 0;
      end
    end
  end

endmodule

/* verification/sync_fifo_tb.sv */
`timescale 1ns/100ps

// Testbench for the synchronous FIFO
// A table of request patterns is applied row by row and a separate
// monitor compares the DUT against a reference queue
module sync_fifo_tb;

  localparam int clk_period    = 20;
  localparam int drive_delay   = 2;
  localparam int reset_cycles  = 16;
  localparam int margin_cycles = 50;
  localparam int num_rows      = 10;
  localparam int name_bits     = 8 * 20;
  localparam logic [31:0] lfsr_seed = 32'h74b22e47;
  // Feedback mask of a maximal length 32-bit Galois LFSR
  localparam logic [31:0] lfsr_taps = 32'h80200003;

  // One row holds a test name, the request levels and how many cycles they last
  typedef struct packed {
    logic [name_bits-1:0] name;
    logic                 push;
    logic                 pop;
    logic                 flush;
    logic [15:0]          repeats;
  } test_row_t;

  logic                                      clk = 1'b0;
  logic                                      rst_n;
  logic                                      flush;
  logic                                      push;
  logic                                      pop;
  fifo_payload_pkg::data_t                   push_data;
  fifo_payload_pkg::data_t                   pop_data;
  logic                                      full;
  logic                                      empty;
  logic [fifo_geometry_pkg::count_width-1:0] count;
  logic                                      test_end;
  logic [name_bits-1:0]                      test_name;
  int                                        error_count;
  int                                        tests_run;
  int                                        tests_failed;
  logic [31:0]                               lfsr_state;
  test_row_t                                 table_rows [num_rows];

  always #(clk_period / 2) clk = ~clk;

  sync_fifo dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush    (flush),
    .push     (push),
    .push_data(push_data),
    .pop      (pop),
    .pop_data (pop_data),
    .full     (full),
    .empty    (empty),
    .count    (count)
  );

  fifo_checker monitor (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .push        (push),
    .push_data   (push_data),
    .pop         (pop),
    .pop_data    (pop_data),
    .full        (full),
    .empty       (empty),
    .count       (count),
    .test_end    (test_end),
    .test_name   (test_name),
    .error_count (error_count),
    .tests_run   (tests_run),
    .tests_failed(tests_failed)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ lfsr_taps;
    end else begin
      return state >> 1;
    end
  endfunction

  // Each data bit costs one LFSR step
  task automatic draw_word(output fifo_payload_pkg::data_t word);
    for (int b = 0; b < fifo_payload_pkg::data_width; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      word[b] = lfsr_state[0];
    end
  endtask

  task automatic set_row(input int idx, input logic [name_bits-1:0] name, input logic push_bit,
                         input logic pop_bit, input logic flush_bit, input int repeats);
    table_rows[idx] = '{name, push_bit, pop_bit, flush_bit, 16'(repeats)};
  endtask

  // ----------------------------------------
  // Test table
  // ----------------------------------------

  task automatic build_table();
    set_row(0, "reset_state", 1'b0, 1'b0, 1'b0, 2);
    // Eight pushes into six entries, the last two are lost
    set_row(1, "fill_past_full", 1'b1, 1'b0, 1'b0, 8);
    // Only the pop goes through, count drops to five
    set_row(2, "push_pop_at_full", 1'b1, 1'b1, 1'b0, 1);
    set_row(3, "drain_past_empty", 1'b0, 1'b1, 1'b0, 8);
    set_row(4, "refill_partial", 1'b1, 1'b0, 1'b0, 3);
    // Twenty steady cycles send both pointers around the ring several times
    set_row(5, "push_pop_stream", 1'b1, 1'b1, 1'b0, 20);
    set_row(6, "flush_with_push", 1'b1, 1'b0, 1'b1, 1);
    set_row(7, "idle_after_flush", 1'b0, 1'b0, 1'b0, 2);
    set_row(8, "push_after_flush", 1'b1, 1'b0, 1'b0, 2);
    set_row(9, "pop_after_flush", 1'b0, 1'b1, 1'b0, 3);
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  initial begin : stimulus
    fifo_payload_pkg::data_t word;

    rst_n      = 1'b0;
    flush      = 1'b0;
    push       = 1'b0;
    pop        = 1'b0;
    push_data  = '0;
    test_end   = 1'b0;
    test_name  = '0;
    lfsr_state = lfsr_seed;
    build_table();

    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    rst_n = 1'b1;

    for (int i = 0; i < num_rows; i++) begin
      test_name = table_rows[i].name;
      for (int r = 0; r < int'(table_rows[i].repeats); r++) begin
        draw_word(word);
        push      = table_rows[i].push;
        pop       = table_rows[i].pop;
        flush     = table_rows[i].flush;
        push_data = word;
        @(posedge clk);
        #drive_delay;
      end
      // One quiet cycle lets the monitor see the last result of the row
      push     = 1'b0;
      pop      = 1'b0;
      flush    = 1'b0;
      test_end = 1'b1;
      @(posedge clk);
      #drive_delay;
      test_end = 1'b0;
    end

    @(posedge clk);
    $display("Tests run %0d, failed %0d, value errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0 && tests_run == num_rows) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Limit is the reset plus every row and its quiet cycle, with some slack
  initial begin : watchdog
    int total_cycles;

    #1;
    total_cycles = reset_cycles + 2 + margin_cycles;
    for (int i = 0; i < num_rows; i++) begin
      total_cycles += int'(table_rows[i].repeats) + 1;
    end
    #(total_cycles * clk_period);
    $display("Run timed out after %0d cycles before the test table finished", total_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* sync_fifo.f */
source/fifo_geometry_pkg.sv
source/fifo_payload_pkg.sv
source/up_down_counter.sv
source/fifo_control.sv
source/fifo_storage.sv
source/sync_fifo.sv
verification/fifo_checker.sv
verification/sync_fifo_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the FIFO testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

rm -rf obj_dir

verilator --binary --timing -j 0 --top-module sync_fifo_tb -f sync_fifo.f \
    -o sync_fifo_sim > "$build_log" 2>&1 \
  && ./obj_dir/sync_fifo_sim > "$sim_log" 2>&1 \
  || { cat "$build_log"; echo "Build or simulation did not complete"; exit 1; }

cat "$sim_log"

grep -q "TESTBENCH FAILED" "$sim_log" \
  && { echo "Simulation reported a failure"; exit 1; } \
  || { echo "Simulation finished without failures"; exit 0; }
